// File: common/flash_cfg_macros.svh
`ifndef FLASH_CFG_MACROS_SVH
`define FLASH_CFG_MACROS_SVH

// number of channel_config blocks behind the router
`define FC_NUM_CHANNELS 4

// serial flash standard read, no dummy cycles
`define FC_READ_CMD 8'h03

// bitstream image sits at the bottom of flash
`define FC_START_ADDR 24'h000000

// clk cycles per sck half period
`define FC_SCK_HALF 2

// upper bound on the length word
`define FC_MAX_WORDS 255

`endif

// File: common/flash_cfg_pkg.sv
package flash_cfg_pkg;

    // reader sequencing, one pass per read_bitstream
    typedef enum logic [2:0]
    {
        IDLE    = 3'd0,  // cs_n high, waiting
        COMMAND = 3'd1,  // read opcode + address out on mosi
        LENGTH  = 3'd2,  // first word back is the word count
        DATA    = 3'd3,  // config words
        DONE    = 3'd4   // release cs_n, pulse end_bitstream
    } reader_state_t;

    // top nibble of every config word
    typedef enum logic [3:0]
    {
        CFG_NOP   = 4'h0,
        CFG_WRITE = 4'h1,
        CFG_CLEAR = 4'h2,
        CFG_ARM   = 4'h3
    } cfg_op_t;

    typedef logic [23:0] checksum_t;  // payload, checksum and config value share a width
    typedef logic [15:0] count_t;

    typedef struct packed
    {
        cfg_op_t    op;       // [31:28]
        logic [3:0] chan;     // [27:24]
        checksum_t  payload;  // [23:0]
    } cfg_word_t;

endpackage

// File: spi_flash_reader/spi_flash_reader.sv
`timescale 1ns/1ps
`include "flash_cfg_macros.svh"

module spi_flash_reader
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     read_bitstream,
    output logic                     spi_sck,
    output logic                     spi_cs_n,
    output logic                     spi_mosi,
    input  logic                     spi_miso,
    output logic                     word_valid,
    output flash_cfg_pkg::cfg_word_t word,
    output logic                     end_bitstream,
    output logic                     busy
);

    localparam int DIV_W  = $clog2(`FC_SCK_HALF + 1);
    localparam int WCNT_W = $clog2(`FC_MAX_WORDS + 1);

    flash_cfg_pkg::reader_state_t state;

    logic [DIV_W-1:0]  div_cnt;     // clk count inside one sck half period
    logic              shifting;    // sck running
    logic              sck_tick;    // end of a half period
    logic              rise_edge;   // sck about to go high, sample miso
    logic              fall_edge;   // sck about to go low, next mosi bit
    logic [31:0]       sreg_out;    // command + address, msb first
    logic [31:0]       sreg_in;     // miso collects here
    logic [4:0]        bit_cnt;     // bit within current 32-bit word
    logic              word_end;    // last falling edge of a word
    logic [WCNT_W-1:0] words_left;  // data words still to come

    //*********************************************************************
    // sck generation
    //*********************************************************************
    assign shifting = state inside {flash_cfg_pkg::COMMAND, flash_cfg_pkg::LENGTH,
                                    flash_cfg_pkg::DATA};
    assign sck_tick  = shifting && (div_cnt == DIV_W'(`FC_SCK_HALF - 1));
    assign rise_edge = sck_tick && !spi_sck;
    assign fall_edge = sck_tick && spi_sck;
    assign word_end  = fall_edge && (bit_cnt == 5'd31);

    always_ff @(posedge clk)
    begin
        if (reset || !shifting)
            div_cnt <= '0;
        else if (sck_tick)
            div_cnt <= '0;  // next half period
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            spi_sck <= 1'b0;  // mode 0, idles low
        else if (sck_tick)
            spi_sck <= !spi_sck;
    end

    //*********************************************************************
    // dual shift register and bit counter
    //*********************************************************************
    assign spi_mosi = sreg_out[31];

    always_ff @(posedge clk)
    begin
        if (reset)
            sreg_out <= '0;
        else if (state == flash_cfg_pkg::IDLE && read_bitstream)
            sreg_out <= {`FC_READ_CMD, `FC_START_ADDR};  // msb goes out with cs_n
        else if (fall_edge)
            sreg_out <= {sreg_out[30:0], 1'b0};  // zeros after the address
    end

    always_ff @(posedge clk)
    begin
        if (rise_edge)
            sreg_in <= {sreg_in[30:0], spi_miso};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            bit_cnt <= '0;
        else if (state == flash_cfg_pkg::IDLE)
            bit_cnt <= '0;
        else if (fall_edge)
            bit_cnt <= bit_cnt + 1'b1;  // wraps at each word
    end

    // data word out, valid with word_valid
    always_ff @(posedge clk)
    begin
        if (state == flash_cfg_pkg::DATA && word_end)
            word <= flash_cfg_pkg::cfg_word_t'(sreg_in);
    end

    //*********************************************************************
    // read sequence
    //*********************************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state         <= flash_cfg_pkg::IDLE;
            spi_cs_n      <= 1'b1;
            busy          <= 1'b0;
            word_valid    <= 1'b0;
            end_bitstream <= 1'b0;
            words_left    <= '0;
        end
        else
        begin
            word_valid    <= 1'b0;  // strobes by default
            end_bitstream <= 1'b0;
            case (state)
                flash_cfg_pkg::IDLE:
                begin
                    if (read_bitstream)  // start, only seen here so ignored while busy
                    begin
                        state    <= flash_cfg_pkg::COMMAND;
                        spi_cs_n <= 1'b0;
                        busy     <= 1'b1;
                    end
                end
                flash_cfg_pkg::COMMAND:
                begin
                    if (word_end)
                        state <= flash_cfg_pkg::LENGTH;
                end
                flash_cfg_pkg::LENGTH:
                begin
                    if (word_end)
                    begin
                        if (sreg_in > `FC_MAX_WORDS)
                            words_left <= WCNT_W'(`FC_MAX_WORDS);  // clamp
                        else
                            words_left <= sreg_in[WCNT_W-1:0];
                        if (sreg_in == 32'd0)
                            state <= flash_cfg_pkg::DONE;  // empty image
                        else
                            state <= flash_cfg_pkg::DATA;
                    end
                end
                flash_cfg_pkg::DATA:
                begin
                    if (word_end)
                    begin
                        word_valid <= 1'b1;
                        words_left <= words_left - 1'b1;
                        if (words_left == WCNT_W'(1))
                            state <= flash_cfg_pkg::DONE;
                    end
                end
                flash_cfg_pkg::DONE:
                begin
                    spi_cs_n      <= 1'b1;  // one cycle after the last word
                    busy          <= 1'b0;
                    end_bitstream <= 1'b1;
                    state         <= flash_cfg_pkg::IDLE;
                end
                default:
                    state <= flash_cfg_pkg::IDLE;
            endcase
        end
    end

    // flash deselected whenever the FSM rests
    a_cs_idle: assert property (@(posedge clk) disable iff (reset)
        (state == flash_cfg_pkg::IDLE) |-> spi_cs_n);

    // every word is taken while the flash is still selected
    a_valid_cs: assert property (@(posedge clk) disable iff (reset)
        word_valid |-> !spi_cs_n);

endmodule

// File: logic/bitstream_router.sv
`timescale 1ns/1ps
`include "flash_cfg_macros.svh"

module bitstream_router
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         word_valid,
    input  flash_cfg_pkg::cfg_word_t     word,
    output logic [`FC_NUM_CHANNELS-1:0]  chan_strobe,
    output flash_cfg_pkg::cfg_op_t       op,
    output flash_cfg_pkg::checksum_t     payload,
    output flash_cfg_pkg::count_t        dropped_count
);

    logic in_range;  // channel field addresses a real channel

    assign in_range = (word.chan < `FC_NUM_CHANNELS);

    // one-hot strobe, one cycle after word_valid
    always_ff @(posedge clk)
    begin
        if (reset)
            chan_strobe <= '0;
        else
        begin
            for (int i = 0; i < `FC_NUM_CHANNELS; i++)
                chan_strobe[i] <= word_valid && (word.chan == 4'(i));
        end
    end

    // shared by all channels, qualified by the strobe
    always_ff @(posedge clk)
    begin
        if (word_valid)
        begin
            op      <= word.op;
            payload <= word.payload;
        end
    end

    // words for missing channels, kept across runs
    always_ff @(posedge clk)
    begin
        if (reset)
            dropped_count <= '0;
        else if (word_valid && !in_range)
            dropped_count <= dropped_count + 1'b1;
    end

    a_strobe_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(chan_strobe));

endmodule

// File: logic/channel_config.sv
`timescale 1ns/1ps

module channel_config
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     strobe,
    input  flash_cfg_pkg::cfg_op_t   op,
    input  flash_cfg_pkg::checksum_t payload,
    output flash_cfg_pkg::checksum_t config_val,
    output flash_cfg_pkg::checksum_t checksum,
    output flash_cfg_pkg::count_t    count,
    output logic                     armed,
    output logic                     error
);

    //*********************************************************************
    // per-channel register file
    //*********************************************************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            config_val <= '0;
            checksum   <= '0;
            count      <= '0;
            armed      <= 1'b0;
            error      <= 1'b0;
        end
        else if (strobe)
        begin
            case (op)
                flash_cfg_pkg::CFG_WRITE:
                begin
                    config_val <= payload;             // last write wins
                    checksum   <= checksum ^ payload;  // running xor
                    count      <= count + 1'b1;
                end
                flash_cfg_pkg::CFG_CLEAR:
                begin
                    config_val <= '0;
                    checksum   <= '0;
                    count      <= '0;
                    armed      <= 1'b0;
                    error      <= 1'b0;
                end
                flash_cfg_pkg::CFG_ARM:
                begin
                    // payload carries the expected checksum
                    if (payload == checksum)
                    begin
                        armed <= 1'b1;
                        error <= 1'b0;
                    end
                    else
                    begin
                        armed <= 1'b0;  // bad image never arms
                        error <= 1'b1;
                    end
                end
                default:
                begin
                    // nop and unused codes leave the channel alone
                end
            endcase
        end
    end

    a_arm_xor_err: assert property (@(posedge clk) disable iff (reset)
        !(armed && error));

endmodule

// File: logic/status_collector.sv
`timescale 1ns/1ps
`include "flash_cfg_macros.svh"

module status_collector
(
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             read_bitstream,
    input  logic                                             end_bitstream,
    input  flash_cfg_pkg::checksum_t [`FC_NUM_CHANNELS-1:0]  config_all,
    input  flash_cfg_pkg::checksum_t [`FC_NUM_CHANNELS-1:0]  checksum_all,
    input  flash_cfg_pkg::count_t [`FC_NUM_CHANNELS-1:0]     count_all,
    input  logic [`FC_NUM_CHANNELS-1:0]                      armed_all,
    input  logic [`FC_NUM_CHANNELS-1:0]                      error_all,
    input  logic [1:0]                                       rd_chan,
    output flash_cfg_pkg::checksum_t                         rd_config,
    output flash_cfg_pkg::checksum_t                         rd_checksum,
    output flash_cfg_pkg::count_t                            rd_count,
    output logic [`FC_NUM_CHANNELS-1:0]                      armed,
    output logic [`FC_NUM_CHANNELS-1:0]                      cfg_error,
    output logic                                             load_done
);

    logic end_d1;  // end_bitstream, 1 cycle late
    logic end_d2;  // 2 cycles late, last channel write has landed

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            end_d1 <= 1'b0;
            end_d2 <= 1'b0;
        end
        else
        begin
            end_d1 <= end_bitstream;
            end_d2 <= end_d1;
        end
    end

    // snapshot of the flags at end of stream
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            armed     <= '0;
            cfg_error <= '0;
            load_done <= 1'b0;
        end
        else if (end_d2)
        begin
            armed     <= armed_all;
            cfg_error <= error_all;
            load_done <= 1'b1;  // held until the next load request
        end
        else if (read_bitstream)
            load_done <= 1'b0;
    end

    // live readback, no latching
    assign rd_config   = config_all[rd_chan];
    assign rd_checksum = checksum_all[rd_chan];
    assign rd_count    = count_all[rd_chan];

endmodule

// File: logic/flash_cfg_top.sv
`timescale 1ns/1ps
`include "flash_cfg_macros.svh"

module flash_cfg_top
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         read_bitstream,
    input  logic                         spi_miso,
    input  logic [1:0]                   rd_chan,
    output logic                         spi_sck,
    output logic                         spi_cs_n,
    output logic                         spi_mosi,
    output flash_cfg_pkg::checksum_t     rd_config,
    output flash_cfg_pkg::checksum_t     rd_checksum,
    output flash_cfg_pkg::count_t        rd_count,
    output logic [`FC_NUM_CHANNELS-1:0]  armed,
    output logic [`FC_NUM_CHANNELS-1:0]  cfg_error,
    output flash_cfg_pkg::count_t        dropped_count,
    output logic                         load_done,
    output logic                         busy
);

    // reader to router
    logic                     word_valid;
    flash_cfg_pkg::cfg_word_t word;
    logic                     end_bitstream;

    // router to channels
    logic [`FC_NUM_CHANNELS-1:0] chan_strobe;
    flash_cfg_pkg::cfg_op_t      chan_op;
    flash_cfg_pkg::checksum_t    chan_payload;

    // channels to collector
    flash_cfg_pkg::checksum_t [`FC_NUM_CHANNELS-1:0] config_all;
    flash_cfg_pkg::checksum_t [`FC_NUM_CHANNELS-1:0] checksum_all;
    flash_cfg_pkg::count_t [`FC_NUM_CHANNELS-1:0]    count_all;
    logic [`FC_NUM_CHANNELS-1:0]                     armed_all;
    logic [`FC_NUM_CHANNELS-1:0]                     error_all;

    spi_flash_reader u_spi_flash_reader
    (
        .clk            (clk),
        .reset          (reset),
        .read_bitstream (read_bitstream),
        .spi_sck        (spi_sck),
        .spi_cs_n       (spi_cs_n),
        .spi_mosi       (spi_mosi),
        .spi_miso       (spi_miso),
        .word_valid     (word_valid),
        .word           (word),
        .end_bitstream  (end_bitstream),
        .busy           (busy)
    );

    bitstream_router u_bitstream_router
    (
        .clk           (clk),
        .reset         (reset),
        .word_valid    (word_valid),
        .word          (word),
        .chan_strobe   (chan_strobe),
        .op            (chan_op),
        .payload       (chan_payload),
        .dropped_count (dropped_count)
    );

    //*********************************************************************
    // one channel_config per strobe bit
    //*********************************************************************
    for (genvar i = 0; i < `FC_NUM_CHANNELS; i++)
    begin : g_chan
        channel_config u_channel_config
        (
            .clk        (clk),
            .reset      (reset),
            .strobe     (chan_strobe[i]),
            .op         (chan_op),
            .payload    (chan_payload),
            .config_val (config_all[i]),
            .checksum   (checksum_all[i]),
            .count      (count_all[i]),
            .armed      (armed_all[i]),
            .error      (error_all[i])
        );
    end

    status_collector u_status_collector
    (
        .clk            (clk),
        .reset          (reset),
        .read_bitstream (read_bitstream),
        .end_bitstream  (end_bitstream),
        .config_all     (config_all),
        .checksum_all   (checksum_all),
        .count_all      (count_all),
        .armed_all      (armed_all),
        .error_all      (error_all),
        .rd_chan        (rd_chan),
        .rd_config      (rd_config),
        .rd_checksum    (rd_checksum),
        .rd_count       (rd_count),
        .armed          (armed),
        .cfg_error      (cfg_error),
        .load_done      (load_done)
    );

endmodule

// File: dv/spi_flash_model.sv
`timescale 1ns/1ps
`include "flash_cfg_macros.svh"

module spi_flash_model
(
    input  logic spi_sck,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic spi_miso,
    output logic cmd_ok
);

    logic [31:0] mem [0:511];  // word image, address 0 holds the length word
    logic [31:0] cmd_shift;     // opcode + address as received
    logic [13:0] bit_idx;       // output bit since the end of the address
    logic        miso_q = 1'b0;

    assign spi_miso = miso_q;

    // pad pattern is a NOP to channel 0, payload carries the word address
    task automatic fill_nop;
        for (int i = 0; i < 512; i++)
            mem[i[8:0]] = {8'h00, 15'd0, i[8:0]};
    endtask

    //*********************************************************************
    // one read transaction per cs_n low period
    //*********************************************************************
    always @(negedge spi_cs_n)
    begin
        // mode 0, mosi sampled on the rising sck edge
        for (int b = 0; b < 32; b++)
        begin
            @(posedge spi_sck);
            cmd_shift = {cmd_shift[30:0], spi_mosi};
        end
        cmd_ok = (cmd_shift == {`FC_READ_CMD, `FC_START_ADDR});
        bit_idx = '0;  // start address is zero, so word 0 goes out first
        while (!spi_cs_n)
        begin
            @(negedge spi_sck or posedge spi_cs_n);
            if (!spi_cs_n)
            begin
                miso_q <= mem[bit_idx[13:5]][5'd31 - bit_idx[4:0]];  // msb first
                bit_idx = bit_idx + 14'd1;
            end
        end
    end

endmodule

// File: dv/flash_cfg_tb.sv
`timescale 1ns/1ps
`include "flash_cfg_macros.svh"

module flash_cfg_tb;

    localparam int WAIT_LIMIT = 40000;  // clk cycles, longest image needs about 33k

    logic                        clk = 1'b0;
    logic                        reset = 1'b1;
    logic                        read_bitstream = 1'b0;
    logic [1:0]                  rd_chan = 2'd0;
    logic                        spi_sck;
    logic                        spi_cs_n;
    logic                        spi_mosi;
    logic                        spi_miso;
    flash_cfg_pkg::checksum_t    rd_config;
    flash_cfg_pkg::checksum_t    rd_checksum;
    flash_cfg_pkg::count_t       rd_count;
    logic [`FC_NUM_CHANNELS-1:0] armed;
    logic [`FC_NUM_CHANNELS-1:0] cfg_error;
    flash_cfg_pkg::count_t       dropped_count;
    logic                        load_done;
    logic                        busy;
    logic                        cmd_ok;

    // expected state from the trace
    flash_cfg_pkg::checksum_t    exp_config [`FC_NUM_CHANNELS];
    flash_cfg_pkg::checksum_t    exp_checksum [`FC_NUM_CHANNELS];
    flash_cfg_pkg::count_t       exp_count [`FC_NUM_CHANNELS];
    logic [`FC_NUM_CHANNELS-1:0] exp_armed;
    logic [`FC_NUM_CHANNELS-1:0] exp_error;
    flash_cfg_pkg::count_t       exp_dropped;
    logic [31:0]                 rng_state = 32'hf52f_a800;
    int                          run_id;

    always #20 clk = !clk;  // 40 ns period

    flash_cfg_top u_flash_cfg_top
    (
        .clk            (clk),
        .reset          (reset),
        .read_bitstream (read_bitstream),
        .spi_miso       (spi_miso),
        .rd_chan        (rd_chan),
        .spi_sck        (spi_sck),
        .spi_cs_n       (spi_cs_n),
        .spi_mosi       (spi_mosi),
        .rd_config      (rd_config),
        .rd_checksum    (rd_checksum),
        .rd_count       (rd_count),
        .armed          (armed),
        .cfg_error      (cfg_error),
        .dropped_count  (dropped_count),
        .load_done      (load_done),
        .busy           (busy)
    );

    spi_flash_model u_flash_model
    (
        .spi_sck  (spi_sck),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .cmd_ok   (cmd_ok)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_failure;
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    //*********************************************************************
    // compare tasks
    //*********************************************************************
    task automatic check_config(input string what, input flash_cfg_pkg::checksum_t got,
                                input flash_cfg_pkg::checksum_t expected);
        if (got !== expected)
        begin
            $display("MISMATCH at %0t, %s got %h expected %h", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string what, input flash_cfg_pkg::count_t got,
                               input flash_cfg_pkg::count_t expected);
        if (got !== expected)
        begin
            $display("MISMATCH at %0t, %s got %0d expected %0d", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_flags(input string what, input logic [`FC_NUM_CHANNELS-1:0] got,
                               input logic [`FC_NUM_CHANNELS-1:0] expected);
        if (got !== expected)
        begin
            $display("MISMATCH at %0t, %s got %b expected %b", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("MISMATCH at %0t, %s got %b expected %b", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    //*********************************************************************
    // run sequencing
    //*********************************************************************
    task automatic wait_busy_low;
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (busy)
        begin
            $display("busy still high after %0d clk cycles in run %0d", WAIT_LIMIT, run_id);
            stop_on_failure();
        end
    endtask

    task automatic wait_load_done;
        int n;
        n = 0;
        while (!load_done && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!load_done)
        begin
            $display("load_done never rose in run %0d", run_id);
            stop_on_failure();
        end
    endtask

    // random idle gap, then a one-cycle request
    task automatic pulse_read;
        int gap;
        rng_state = xorshift32(rng_state);
        gap = int'(rng_state[3:0]);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        read_bitstream <= 1'b1;
        @(posedge clk);
        read_bitstream <= 1'b0;
        @(negedge clk);
        check_level("load_done after read_bitstream", load_done, 1'b0);
        check_level("busy after read_bitstream", busy, 1'b1);
    endtask

    task automatic check_results;
        check_level("read command at the flash", cmd_ok, 1'b1);
        check_flags("armed", armed, exp_armed);
        check_flags("cfg_error", cfg_error, exp_error);
        check_count("dropped_count", dropped_count, exp_dropped);
        for (int c = 0; c < `FC_NUM_CHANNELS; c++)
        begin
            @(posedge clk);
            rd_chan <= 2'(c);  // readback mux is combinational
            @(negedge clk);
            check_config($sformatf("run %0d ch%0d config", run_id, c), rd_config,
                         exp_config[c[1:0]]);
            check_config($sformatf("run %0d ch%0d checksum", run_id, c), rd_checksum,
                         exp_checksum[c[1:0]]);
            check_count($sformatf("run %0d ch%0d count", run_id, c), rd_count,
                        exp_count[c[1:0]]);
        end
    endtask

    task automatic run_image;
        pulse_read();
        wait_busy_low();
        wait_load_done();
        check_results();
    endtask

    //*********************************************************************
    // trace driven main sequence
    //*********************************************************************
    initial
    begin
        int                       fd;
        int                       code;
        logic [63:0]              tag;
        logic [8*160-1:0]         rest;
        logic [8:0]               addr;
        logic [31:0]              data;
        int                       ch;
        flash_cfg_pkg::checksum_t cfg_v;
        flash_cfg_pkg::checksum_t sum_v;
        int                       cnt_v;
        int                       arm_v;
        int                       err_v;
        int                       drop_v;
        logic                     done;

        done = 1'b0;
        fd = $fopen("dv/bitstream_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open dv/bitstream_trace.txt");
            stop_on_failure();
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (!done)
        begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1)
            begin
                $display("trace ended before its end line");
                stop_on_failure();
            end
            else if (tag == 64'("#"))
                code = $fgets(rest, fd);  // comment line
            else if (tag == 64'("run"))
            begin
                code = $fscanf(fd, "%d", run_id);
                u_flash_model.fill_nop();  // fresh image, NOP padded
            end
            else if (tag == 64'("w"))
            begin
                code = $fscanf(fd, "%h %h", addr, data);
                u_flash_model.mem[addr] = data;
            end
            else if (tag == 64'("ch"))
            begin
                code = $fscanf(fd, "%d %h %h %d %d %d", ch, cfg_v, sum_v, cnt_v, arm_v, err_v);
                exp_config[ch[1:0]]   = cfg_v;
                exp_checksum[ch[1:0]] = sum_v;
                exp_count[ch[1:0]]    = 16'(cnt_v);
                exp_armed[ch[1:0]]    = arm_v[0];
                exp_error[ch[1:0]]    = err_v[0];
            end
            else if (tag == 64'("drop"))
            begin
                code = $fscanf(fd, "%d", drop_v);
                exp_dropped = 16'(drop_v);
                run_image();  // drop line closes a run
            end
            else if (tag == 64'("end"))
                done = 1'b1;
            else
            begin
                $display("unknown keyword in dv/bitstream_trace.txt");
                stop_on_failure();
            end
        end
        $fclose(fd);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: dv/bitstream_trace.txt
# w addr(hex) word(hex) loads the flash image, address 0 is the length word
# ch chan config(hex) checksum(hex) count armed error, then drop count runs the image
run 1
w 000 00000008
w 001 10000011
w 002 11000022
w 003 12000033
w 004 13000044
w 005 1000a5a0
w 006 15abcdef
w 007 1213f00d
w 008 3f000000
ch 0 00a5a0 00a5b1 2 0 0
ch 1 000022 000022 1 0 0
ch 2 13f00d 13f03e 2 0 0
ch 3 000044 000044 1 0 0
drop 2
run 2
w 000 00000008
w 001 10000100
w 002 21000000
w 003 11005500
w 004 11000055
w 005 31005555
w 006 3213f03e
w 007 33000045
w 008 04000000
ch 0 000100 00a4b1 3 0 0
ch 1 000055 005555 2 1 0
ch 2 13f00d 13f03e 2 1 0
ch 3 000044 000044 1 0 1
drop 3
run 3
w 000 00000000
ch 0 000100 00a4b1 3 0 0
ch 1 000055 005555 2 1 0
ch 2 13f00d 13f03e 2 1 0
ch 3 000044 000044 1 0 1
drop 3
run 4
w 000 0000012c
w 001 20000000
w 002 10000001
w 0ff 10000002
w 100 10000004
w 101 17000000
ch 0 000002 000003 2 0 0
ch 1 000055 005555 2 1 0
ch 2 13f00d 13f03e 2 1 0
ch 3 000044 000044 1 0 1
drop 3
end

// File: sources.f
+incdir+common
common/flash_cfg_pkg.sv
spi_flash_reader/spi_flash_reader.sv
logic/bitstream_router.sv
logic/channel_config.sv
logic/status_collector.sv
logic/flash_cfg_top.sv
dv/spi_flash_model.sv
dv/flash_cfg_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the flash config testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module flash_cfg_tb \
    -f sources.f \
    -Mdir obj_dir

# exit status of the simulation is the pass or fail result
./obj_dir/Vflash_cfg_tb
